//--- ram_access_top.f
src/ram_access_pkg.sv
src/ram_mode_ctrl.sv
src/ram_port_mux.sv
src/ram_array.sv
src/ram_read_capture.sv
src/ram_access_top.sv
tb/ram_access_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns
LINT     = --lint-only -Wall --timing --timescale 1ns/1ns
TOP      = ram_access_tb
RTL_TOP  = ram_access_top
FILELIST = ram_access_top.f
OBJ_DIR  = obj_dir
PASS_MSG = No errors

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the pipeline status is the status of grep, so a missing pass line fails the target
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

lint:
	$(SIM) $(LINT) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/ram_access_tb.sv
// ----------------------------------------
// random traffic testbench for ram_access_top with a reference model
// the whole array is written before random reads, so no read sees X
// self-test entry takes two drain cycles after ready falls
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ram_access_tb;

  localparam int DEPTH       = 256;
  localparam int RST_CYCLES  = 2;
  localparam int N_WR        = 32;
  localparam int N_RAND      = 300;
  localparam int N_BYP       = 16;
  localparam int N_BIST      = 16;
  localparam int MODE_WAIT   = 20;
  localparam int DRAIN       = 3;
  localparam int STIM_CYCLES = RST_CYCLES + 2 * N_WR + DEPTH + N_RAND + N_BYP
                               + 3 * N_BIST + 10 * DRAIN;
  localparam int LIMIT       = STIM_CYCLES + 3 * MODE_WAIT + 50;

  typedef struct {
    int                    due;
    logic                  bist;
    ram_access_pkg::data_t data;
  } exp_rsp_t;

  logic                      clk = 1'b0;
  logic                      mbist_ramaccess_rst_;
  ram_access_pkg::wr_req_t   wr;
  ram_access_pkg::rd_req_t   rd;
  logic                      bypass;
  ram_access_pkg::bist_req_t bist;
  logic                      mbist_en;
  logic                      ready;
  ram_access_pkg::rd_rsp_t   rd_rsp;
  ram_access_pkg::rd_rsp_t   mbist_rsp;

  // reference model
  ram_access_pkg::data_t model_mem [DEPTH];
  exp_rsp_t              exp_q [$];
  ram_access_pkg::addr_t addr_list [$];
  int                    cyc = 0;
  int                    fails = 0;
  int                    checks = 0;
  int                    tests = 0;
  int                    test_fails = 0;
  string                 test_name;
  logic                  ready_known = 1'b0;
  logic                  exp_ready = 1'b0;

  ram_access_top #(
    .DEPTH       (DEPTH),
    .SYNC_STAGES (2)
  ) uut (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .wr                   (wr),
    .rd                   (rd),
    .bypass               (bypass),
    .bist                 (bist),
    .mbist_en             (mbist_en),
    .ready                (ready),
    .rd_rsp               (rd_rsp),
    .mbist_rsp            (mbist_rsp)
  );

  always #2 clk = ~clk;

  // cycle counter and watchdog
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc > LIMIT) begin
      $display("timeout: run went past %0d cycles", LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  // ----------------------------------------
  // stimulus values
  // ----------------------------------------
  function automatic ram_access_pkg::addr_t pick_addr();
    logic [31:0] r;
    r = $urandom();
    return r[ram_access_pkg::ADDR_W-1:0];
  endfunction

  function automatic ram_access_pkg::data_t new_word();
    logic [31:0] r;
    r = $urandom();
    return r[ram_access_pkg::DATA_W-1:0];
  endfunction

  function automatic ram_access_pkg::bist_pat_t new_pattern();
    logic [31:0] r;
    r = $urandom();
    return r[ram_access_pkg::BIST_PAT_W-1:0];
  endfunction

  function automatic logic coin();
    logic [31:0] r;
    r = $urandom();
    return r[0];
  endfunction

  // even bits take di[0], odd bits di[1], so bit 10 is di[0]
  function automatic ram_access_pkg::data_t expand_pattern(input ram_access_pkg::bist_pat_t di);
    return {di[0], {5{di}}};
  endfunction

  // ----------------------------------------
  // checks
  // ----------------------------------------
  task automatic note_fail();
    fails++;
    test_fails++;
  endtask

  task automatic compare_rsp(input string name, input ram_access_pkg::rd_rsp_t got,
                             input ram_access_pkg::rd_rsp_t exp);
    checks++;
    if (got.valid !== exp.valid) begin
      $display("FAIL %s.valid got %h exp %h at cycle %0d", name, got.valid, exp.valid, cyc);
      note_fail();
    end else if (exp.valid && got.data !== exp.data) begin
      $display("FAIL %s.data got %h exp %h at cycle %0d", name, got.data, exp.data, cyc);
      note_fail();
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("FAIL ready got %h exp %h at cycle %0d", got, exp, cyc);
      note_fail();
    end
  endtask

  // one clock, then compare outputs against what is due now
  task automatic next_cycle();
    exp_rsp_t                e;
    ram_access_pkg::rd_rsp_t exp_rd;
    ram_access_pkg::rd_rsp_t exp_mb;
    @(posedge clk);
    #1;
    exp_rd = '0;
    exp_mb = '0;
    if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
      e = exp_q.pop_front();
      if (e.bist) begin
        exp_mb.valid = 1'b1;
        exp_mb.data  = e.data;
      end else begin
        exp_rd.valid = 1'b1;
        exp_rd.data  = e.data;
      end
    end
    compare_rsp("rd_rsp", rd_rsp, exp_rd);
    compare_rsp("mbist_rsp", mbist_rsp, exp_mb);
    if (ready_known) begin
      check_ready(ready, exp_ready);
    end
  endtask

  // ----------------------------------------
  // drivers, called 1 ns after a rising edge
  // ----------------------------------------
  task automatic drive_idle();
    wr     = '0;
    rd     = '0;
    bypass = 1'b0;
    bist   = '0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      drive_idle();
      next_cycle();
    end
  endtask

  // read sees the model before this cycle's write lands
  task automatic func_cycle(input logic wv, input ram_access_pkg::addr_t wa,
                            input ram_access_pkg::data_t wd, input logic rv,
                            input ram_access_pkg::addr_t ra, input logic byp);
    exp_rsp_t e;
    drive_idle();
    if ((wv || rv) && ready !== 1'b1) begin
      $display("functional request at cycle %0d while ready was low", cyc);
      note_fail();
    end
    wr     = '{valid: wv, addr: wa, data: wd};
    rd     = '{valid: rv, addr: ra};
    bypass = byp;
    if (rv) begin
      e.due  = cyc + 2;
      e.bist = 1'b0;
      e.data = byp ? wd : model_mem[ra];
      exp_q.push_back(e);
    end
    if (wv) begin
      model_mem[wa] = wd;
    end
    next_cycle();
  endtask

  task automatic bist_cycle(input logic we, input ram_access_pkg::addr_t wa,
                            input ram_access_pkg::bist_pat_t di, input logic ce,
                            input ram_access_pkg::addr_t ra);
    exp_rsp_t e;
    drive_idle();
    bist = '{we: we, wa: wa, ce: ce, ra: ra, di: di};
    if (ce) begin
      e.due  = cyc + 2;
      e.bist = 1'b1;
      e.data = model_mem[ra];
      exp_q.push_back(e);
    end
    if (we) begin
      model_mem[wa] = expand_pattern(di);
    end
    next_cycle();
  endtask

  task automatic wait_ready(input logic lvl, input string what);
    int n;
    n = 0;
    ready_known = 1'b0;
    while (ready !== lvl && n < MODE_WAIT) begin
      idle_cycles(1);
      n++;
    end
    if (ready !== lvl) begin
      $display("ready did not %s within %0d cycles", what, MODE_WAIT);
      note_fail();
    end
    ready_known = 1'b1;
    exp_ready   = lvl;
  endtask

  task automatic start_test(input string name);
    test_name  = name;
    test_fails = 0;
    tests++;
  endtask

  task automatic finish_test();
    idle_cycles(DRAIN);
    if (test_fails == 0) begin
      $display("test %s passed", test_name);
    end else begin
      $display("test %s failed with %0d mismatches", test_name, test_fails);
    end
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    int                    i;
    ram_access_pkg::addr_t a;
    ram_access_pkg::addr_t b;
    void'($urandom(87741));
    mbist_ramaccess_rst_ = 1'b0;
    mbist_en             = 1'b0;
    drive_idle();
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    mbist_ramaccess_rst_ = 1'b1;

    start_test("reset");
    wait_ready(1'b1, "rise after reset");
    finish_test();

    start_test("write_read");
    for (i = 0; i < N_WR; i++) begin
      a = pick_addr();
      addr_list.push_back(a);
      func_cycle(1'b1, a, new_word(), 1'b0, '0, 1'b0);
    end
    for (i = 0; i < addr_list.size(); i++) begin
      func_cycle(1'b0, '0, '0, 1'b1, addr_list[i], 1'b0);
    end
    finish_test();

    // fill first, then mixed traffic with frequent same-address pairs
    start_test("random");
    for (i = 0; i < DEPTH; i++) begin
      func_cycle(1'b1, ram_access_pkg::addr_t'(i), new_word(), 1'b0, '0, 1'b0);
    end
    for (i = 0; i < N_RAND; i++) begin
      a = pick_addr();
      b = coin() ? a : pick_addr();
      func_cycle(coin(), a, new_word(), coin(), b, 1'b0);
    end
    finish_test();

    start_test("bypass");
    for (i = 0; i < N_BYP; i++) begin
      func_cycle(coin(), pick_addr(), new_word(), 1'b1, pick_addr(), 1'b1);
    end
    finish_test();

    start_test("self_test");
    mbist_en = 1'b1;
    wait_ready(1'b0, "fall after mbist_en rose");
    idle_cycles(2);
    addr_list.delete();
    for (i = 0; i < N_BIST; i++) begin
      a = pick_addr();
      addr_list.push_back(a);
      bist_cycle(1'b1, a, new_pattern(), 1'b0, '0);
    end
    for (i = 0; i < addr_list.size(); i++) begin
      bist_cycle(1'b0, '0, '0, 1'b1, addr_list[i]);
    end
    idle_cycles(DRAIN);
    mbist_en = 1'b0;
    wait_ready(1'b1, "return after mbist_en fell");
    for (i = 0; i < addr_list.size(); i++) begin
      func_cycle(1'b0, '0, '0, 1'b1, addr_list[i], 1'b0);
    end
    finish_test();

    if (exp_q.size() != 0) begin
      $display("%0d expected responses never arrived", exp_q.size());
      note_fail();
    end
    $display("%0d tests, %0d checks, %0d failures", tests, checks, fails);
    if (fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/ram_access_top.sv
// --------------------------------------
// 256x11 RAM access wrapper with functional and self-test ports
// read latency is 2 cycles on both response ports
// functional requests must drop valid while ready is low
// mode change latency depends on SYNC_STAGES
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ram_access_top #(
  parameter int DEPTH       = 256,
  parameter int SYNC_STAGES = 2
) (
  input  wire                            clk,
  input  wire                            mbist_ramaccess_rst_,
  input  wire ram_access_pkg::wr_req_t   wr,
  input  wire ram_access_pkg::rd_req_t   rd,
  input  wire                            bypass,
  input  wire ram_access_pkg::bist_req_t bist,
  input  wire                            mbist_en,
  output logic                           ready,
  output ram_access_pkg::rd_rsp_t        rd_rsp,
  output ram_access_pkg::rd_rsp_t        mbist_rsp
);

  ram_access_pkg::access_mode_e mode;
  logic                         arr_we;
  logic                         arr_re;
  ram_access_pkg::addr_t        arr_wa;
  ram_access_pkg::addr_t        arr_ra;
  ram_access_pkg::data_t        arr_wdata;
  ram_access_pkg::data_t        arr_q;
  logic                         rd_src_bist;

  // --------------------------------------
  // port ownership
  // --------------------------------------
  ram_mode_ctrl #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_mode_ctrl (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .mbist_en             (mbist_en),
    .mode                 (mode),
    .ready                (ready)
  );

  ram_port_mux u_port_mux (
    .clk         (clk),
    .mode        (mode),
    .wr          (wr),
    .rd          (rd),
    .bist        (bist),
    .we          (arr_we),
    .re          (arr_re),
    .wa          (arr_wa),
    .ra          (arr_ra),
    .wdata       (arr_wdata),
    .rd_src_bist (rd_src_bist)
  );

  // --------------------------------------
  // storage and read path
  // --------------------------------------
  ram_array #(
    .DEPTH (DEPTH)
  ) u_array (
    .clk   (clk),
    .we    (arr_we),
    .wa    (arr_wa),
    .wdata (arr_wdata),
    .re    (arr_re),
    .ra    (arr_ra),
    .q     (arr_q)
  );

  // bypass rides along with the read edge
  ram_read_capture u_capture (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .re                   (arr_re),
    .rd_src_bist          (rd_src_bist),
    .bypass               (bypass),
    .wdata                (arr_wdata),
    .q                    (arr_q),
    .rd_rsp               (rd_rsp),
    .mbist_rsp            (mbist_rsp)
  );

endmodule

`default_nettype wire

//--- src/ram_read_capture.sv
// --------------------------------------
// second stage of the two-cycle read path
// one data register serves both response ports
// valid goes to whichever port owned the read
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ram_read_capture (
  input  wire                        clk,
  input  wire                        mbist_ramaccess_rst_,
  input  wire                        re,
  input  wire                        rd_src_bist,
  input  wire                        bypass,
  input  wire ram_access_pkg::data_t wdata,
  input  wire ram_access_pkg::data_t q,
  output ram_access_pkg::rd_rsp_t    rd_rsp,
  output ram_access_pkg::rd_rsp_t    mbist_rsp
);

  logic                  re_d;
  logic                  src_bist_d;
  logic                  bypass_d;
  ram_access_pkg::data_t wdata_d;
  ram_access_pkg::data_t data_q;
  logic                  rd_vld_q;
  logic                  mbist_vld_q;

  // read edge side info
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      re_d        <= 1'b0;
      src_bist_d  <= 1'b0;
      bypass_d    <= 1'b0;
      rd_vld_q    <= 1'b0;
      mbist_vld_q <= 1'b0;
    end else begin
      re_d        <= re;
      src_bist_d  <= rd_src_bist;
      bypass_d    <= bypass;
      rd_vld_q    <= re_d && !src_bist_d;
      mbist_vld_q <= re_d && src_bist_d;
    end
  end

  // data path
  always_ff @(posedge clk) begin
    wdata_d <= wdata;
    if (re_d) begin
      data_q <= bypass_d ? wdata_d : q;
    end
  end

  assign rd_rsp.valid    = rd_vld_q;
  assign rd_rsp.data     = data_q;
  assign mbist_rsp.valid = mbist_vld_q;
  assign mbist_rsp.data  = data_q;

  // the drain states keep the two owners' responses at least a cycle apart
  assert property (@(posedge clk) disable iff (!mbist_ramaccess_rst_)
    !(mbist_rsp.valid && (rd_rsp.valid || $past(rd_rsp.valid))) &&
    !(rd_rsp.valid && $past(mbist_rsp.valid)))
    else $error("functional and self-test responses overlap or touch");

endmodule

`default_nettype wire

//--- src/ram_array.sv
// --------------------------------------
// behavioral two-port memory without reset
// read during write to the same word returns the old word
// DEPTH must not exceed 2**ADDR_W
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ram_array #(
  parameter int DEPTH = 256
) (
  input  wire                        clk,
  input  wire                        we,
  input  wire ram_access_pkg::addr_t wa,
  input  wire ram_access_pkg::data_t wdata,
  input  wire                        re,
  input  wire ram_access_pkg::addr_t ra,
  output ram_access_pkg::data_t      q
);

  ram_access_pkg::data_t mem [DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[wa] <= wdata;
    end
  end

  // read port holds q between reads
  always_ff @(posedge clk) begin
    if (re) begin
      q <= mem[ra];
    end
  end

  // addresses beyond DEPTH would alias nothing in a smaller array
  assert property (@(posedge clk)
    (we |-> (int'(wa) < DEPTH)) and (re |-> (int'(ra) < DEPTH)))
    else $error("array access beyond DEPTH");

endmodule

`default_nettype wire

//--- src/ram_port_mux.sv
// --------------------------------------
// purely combinational port steering
// enables are forced low in the two transition states
// clk only samples the handshake check
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ram_port_mux (
  input  wire                          clk,
  input  wire ram_access_pkg::access_mode_e mode,
  input  wire ram_access_pkg::wr_req_t      wr,
  input  wire ram_access_pkg::rd_req_t      rd,
  input  wire ram_access_pkg::bist_req_t    bist,
  output logic                         we,
  output logic                         re,
  output ram_access_pkg::addr_t        wa,
  output ram_access_pkg::addr_t        ra,
  output ram_access_pkg::data_t        wdata,
  output logic                         rd_src_bist
);

  ram_access_pkg::data_t pat_word;
  logic                  func_sel;
  logic                  bist_sel;

  // pattern bit i%W lands on data bit i, bit 0 ends up on top
  always_comb begin
    for (int i = 0; i < ram_access_pkg::DATA_W; i++) begin
      pat_word[i] = bist.di[i % ram_access_pkg::BIST_PAT_W];
    end
  end

  assign func_sel = (mode == ram_access_pkg::MODE_FUNC);
  assign bist_sel = (mode == ram_access_pkg::MODE_BIST);

  always_comb begin
    we = 1'b0;
    re = 1'b0;
    wa = wr.addr;
    ra = rd.addr;
    if (func_sel) begin
      we = wr.valid;
      re = rd.valid;
    end else if (bist_sel) begin
      we = bist.we;
      re = bist.ce;
      wa = bist.wa;
      ra = bist.ra;
    end
  end

  // write data follows the owner even without a write, for bypass
  assign wdata       = bist_sel ? pat_word : wr.data;
  assign rd_src_bist = bist_sel;

  assert property (@(posedge clk)
    !func_sel |-> !(wr.valid || rd.valid))
    else $error("functional request issued while ready is low");

endmodule

`default_nettype wire

//--- src/ram_mode_ctrl.sv
// --------------------------------------
// mbist_en is asynchronous and goes through SYNC_STAGES flops (min 2)
// the enter and exit states each hold two cycles so reads drain
// ready is registered and rises one clock after reset release
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ram_mode_ctrl #(
  parameter int SYNC_STAGES = 2
) (
  input  wire                          clk,
  input  wire                          mbist_ramaccess_rst_,
  input  wire                          mbist_en,
  output ram_access_pkg::access_mode_e mode,
  output logic                         ready
);

  logic [SYNC_STAGES-1:0]       en_sync_q;
  logic                         en_sync;
  ram_access_pkg::access_mode_e mode_q;
  ram_access_pkg::access_mode_e mode_next;
  logic                         hold_q;
  logic                         in_transition;

  // --------------------------------------
  // enable synchronizer
  // --------------------------------------
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      en_sync_q <= '0;
    end else begin
      en_sync_q <= {en_sync_q[SYNC_STAGES-2:0], mbist_en};
    end
  end

  assign en_sync = en_sync_q[SYNC_STAGES-1];

  // --------------------------------------
  // access mode FSM
  // --------------------------------------
  assign in_transition = (mode_q == ram_access_pkg::MODE_ENTER_BIST) ||
                         (mode_q == ram_access_pkg::MODE_EXIT_BIST);

  always_comb begin
    mode_next = mode_q;
    case (mode_q)
      ram_access_pkg::MODE_FUNC:       if (en_sync) mode_next = ram_access_pkg::MODE_ENTER_BIST;
      ram_access_pkg::MODE_ENTER_BIST: if (hold_q) mode_next = ram_access_pkg::MODE_BIST;
      ram_access_pkg::MODE_BIST:       if (!en_sync) mode_next = ram_access_pkg::MODE_EXIT_BIST;
      ram_access_pkg::MODE_EXIT_BIST:  if (hold_q) mode_next = ram_access_pkg::MODE_FUNC;
      default:                         mode_next = ram_access_pkg::MODE_FUNC;
    endcase
  end

  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      mode_q <= ram_access_pkg::MODE_FUNC;
      hold_q <= 1'b0;
      ready  <= 1'b0;
    end else begin
      mode_q <= mode_next;
      // second cycle of a transition state
      hold_q <= in_transition && (mode_next == mode_q);
      ready  <= (mode_next == ram_access_pkg::MODE_FUNC);
    end
  end

  assign mode = mode_q;

  // self-test is entered only after both cycles of the drain state
  assert property (@(posedge clk) disable iff (!mbist_ramaccess_rst_)
    (mode_q == ram_access_pkg::MODE_BIST) && ($past(mode_q) != ram_access_pkg::MODE_BIST)
      |-> ($past(mode_q) == ram_access_pkg::MODE_ENTER_BIST) &&
          ($past(mode_q, 2) == ram_access_pkg::MODE_ENTER_BIST))
    else $error("mode entered MODE_BIST without two MODE_ENTER_BIST cycles");

endmodule

`default_nettype wire

//--- src/ram_access_pkg.sv
// --------------------------------------
// widths, request/response bundles and the access mode encoding
// DEPTH in the modules must stay at or below 2**ADDR_W
// the self-test pattern is replicated to fill a data word
// --------------------------------------
`default_nettype none

package ram_access_pkg;

  localparam int unsigned ADDR_W     = 8;
  localparam int unsigned DATA_W     = 11;
  localparam int unsigned BIST_PAT_W = 2;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [BIST_PAT_W-1:0] bist_pat_t;

  // functional write request
  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t data;
  } wr_req_t;

  // functional read request
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } rd_req_t;

  // read response, no back-pressure
  typedef struct packed {
    logic  valid;
    data_t data;
  } rd_rsp_t;

  // self-test access port, acted on every cycle in MODE_BIST
  typedef struct packed {
    logic      we;
    addr_t     wa;
    logic      ce;
    addr_t     ra;
    bist_pat_t di;
  } bist_req_t;

  typedef enum logic [1:0] {
    MODE_FUNC,
    MODE_ENTER_BIST,
    MODE_BIST,
    MODE_EXIT_BIST
  } access_mode_e;

endpackage

`default_nettype wire
